/* src/soc_pkg.sv */
package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;  // All zero means a read
  typedef logic [63:0] mtime_t;
  typedef logic [3:0] rom_index_t;

  typedef struct packed {
    logic valid;
    logic instr;  // Set on an instruction fetch
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    logic ready;
    logic error;
    data_t rdata;
  } mem_rsp_t;

  // Address map
  localparam addr_t rom_base = 32'h0000_0000;
  localparam int rom_words = 16;  // Fixed by the size of boot_rom.hex

  localparam addr_t ram_base = 32'h0001_0000;

  localparam addr_t clint_base = 32'h0200_0000;
  localparam addr_t clint_size = 32'h0001_0000;

  // CLINT register offsets, the high words sit at +4
  localparam addr_t msip_offset = 32'h0000_0000;
  localparam addr_t mtimecmp_offset = 32'h0000_4000;
  localparam addr_t mtime_offset = 32'h0000_bff8;

endpackage

/* src/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder #(
  parameter int ram_words = 64
) (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t cpu_req,
  output soc_pkg::mem_rsp_t cpu_rsp,
  output soc_pkg::mem_req_t rom_req,
  output soc_pkg::mem_req_t ram_req,
  output soc_pkg::mem_req_t clint_req,
  input  soc_pkg::mem_rsp_t rom_rsp,
  input  soc_pkg::mem_rsp_t ram_rsp,
  input  soc_pkg::mem_rsp_t clint_rsp
);

  localparam soc_pkg::addr_t rom_bytes = soc_pkg::addr_t'(4 * soc_pkg::rom_words);
  localparam soc_pkg::addr_t ram_bytes = soc_pkg::addr_t'(4 * ram_words);

  soc_pkg::addr_t rom_rel;
  soc_pkg::addr_t ram_rel;
  soc_pkg::addr_t clint_rel;
  logic rom_hit;
  logic ram_hit;
  logic clint_hit;
  logic error_flag;
  logic err_ready;

  // An address below the base wraps around to a large offset and so misses
  always_comb begin
    rom_rel = cpu_req.addr - soc_pkg::rom_base;
    ram_rel = cpu_req.addr - soc_pkg::ram_base;
    clint_rel = cpu_req.addr - soc_pkg::clint_base;
    rom_hit = rom_rel < rom_bytes;
    ram_hit = ram_rel < ram_bytes;
    clint_hit = clint_rel < soc_pkg::clint_size;
  end

  always_comb begin
    error_flag = 1'b0;

    rom_req = cpu_req;
    rom_req.valid = 1'b0;
    rom_req.addr = rom_rel;

    ram_req = cpu_req;
    ram_req.valid = 1'b0;
    ram_req.addr = ram_rel;

    clint_req = cpu_req;
    clint_req.valid = 1'b0;
    clint_req.addr = clint_rel;

    if (cpu_req.valid) begin
      if (rom_hit) begin
        if (cpu_req.wstrb != '0) begin
          error_flag = 1'b1;  // The ROM takes no writes
        end else begin
          rom_req.valid = 1'b1;
        end
      end else if (ram_hit) begin
        ram_req.valid = 1'b1;
      end else if (clint_hit) begin
        if (cpu_req.instr) begin
          error_flag = 1'b1;  // No code runs from the CLINT
        end else begin
          clint_req.valid = 1'b1;
        end
      end else begin
        error_flag = 1'b1;
      end
    end
  end

  // Error answer with the same latency as a target
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      err_ready <= 1'b0;
    end else begin
      err_ready <= error_flag && !err_ready;
    end
  end

  always_comb begin
    if (rom_rsp.ready) begin
      cpu_rsp = rom_rsp;
    end else if (ram_rsp.ready) begin
      cpu_rsp = ram_rsp;
    end else if (clint_rsp.ready) begin
      cpu_rsp = clint_rsp;
    end else if (err_ready) begin
      cpu_rsp = '{ready: 1'b1, error: 1'b1, rdata: '0};
    end else begin
      cpu_rsp = '0;
    end
  end

  one_ready : assert property (@(posedge clock) disable iff (reset == 0)
    $onehot0({rom_rsp.ready, ram_rsp.ready, clint_rsp.ready, err_ready}));

endmodule

/* src/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);

  soc_pkg::data_t words [soc_pkg::rom_words];
  soc_pkg::rom_index_t index;
  soc_pkg::data_t rdata;
  logic ready;

  initial begin
    $readmemh("src/boot_rom.hex", words);
  end

  assign index = req.addr[5:2];

  // One pulse per request, even while valid is still held in the ready cycle
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      ready <= 1'b0;
    end else begin
      ready <= req.valid && !ready;
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      rdata <= words[index];
    end
  end

  assign rsp = '{ready: ready, error: 1'b0, rdata: rdata};

  // Only reads inside the table may reach the ROM since the index drops the upper address bits
  rom_request : assert property (@(posedge clock) disable iff (reset == 0)
    req.valid |-> (req.wstrb == '0 && req.addr < 4 * soc_pkg::rom_words));

endmodule

/* src/scratch_ram.sv */
`timescale 1ns/1ps

module scratch_ram #(
  parameter int ram_words = 64
) (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);

  localparam int index_bits = $clog2(ram_words);

  typedef logic [index_bits-1:0] ram_index_t;

  soc_pkg::data_t mem [ram_words];
  ram_index_t index;
  soc_pkg::data_t rdata;
  logic ready;
  logic first;

  assign index = req.addr[index_bits+1:2];
  assign first = req.valid && !ready;  // Only the first cycle of a request acts

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      ready <= 1'b0;
    end else begin
      ready <= first;
    end
  end

  always_ff @(posedge clock) begin
    if (first) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
      rdata <= mem[index];  // Old word on a write
    end
  end

  assign rsp = '{ready: ready, error: 1'b0, rdata: rdata};

endmodule

/* src/clint.sv */
`timescale 1ns/1ps

module clint (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic              msip,
  output logic              mtip
);

  localparam soc_pkg::addr_t cmp_lo = soc_pkg::mtimecmp_offset;
  localparam soc_pkg::addr_t cmp_hi = soc_pkg::mtimecmp_offset + 32'd4;
  localparam soc_pkg::addr_t time_lo = soc_pkg::mtime_offset;
  localparam soc_pkg::addr_t time_hi = soc_pkg::mtime_offset + 32'd4;

  typedef enum logic {idle, respond} state_t;

  state_t state;
  soc_pkg::mtime_t mtime;
  soc_pkg::mtime_t mtimecmp;
  soc_pkg::addr_t offset;
  soc_pkg::data_t rdata;
  logic accept;
  logic write;

  function automatic soc_pkg::data_t merge(soc_pkg::data_t old, soc_pkg::data_t data,
                                           soc_pkg::strb_t strb);
    soc_pkg::data_t result;
    result = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = data[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign offset = {req.addr[31:2], 2'b00};
  assign accept = req.valid && (state == idle);
  assign write = accept && (req.wstrb != '0);

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      state <= idle;
    end else begin
      case (state)
        idle: if (req.valid) state <= respond;
        respond: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      msip <= 1'b0;
      mtimecmp <= '1;  // Far in the future so mtip stays low
      mtime <= '0;
      mtip <= 1'b0;
    end else begin
      if (write && offset == soc_pkg::msip_offset && req.wstrb[0]) begin
        msip <= req.wdata[0];
      end
      if (write && offset == cmp_lo) begin
        mtimecmp[31:0] <= merge(mtimecmp[31:0], req.wdata, req.wstrb);
      end else if (write && offset == cmp_hi) begin
        mtimecmp[63:32] <= merge(mtimecmp[63:32], req.wdata, req.wstrb);
      end
      // A written half replaces the count for that cycle
      if (write && offset == time_lo) begin
        mtime[31:0] <= merge(mtime[31:0], req.wdata, req.wstrb);
      end else if (write && offset == time_hi) begin
        mtime[63:32] <= merge(mtime[63:32], req.wdata, req.wstrb);
      end else begin
        mtime <= mtime + 64'd1;
      end
      mtip <= mtime >= mtimecmp;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      case (offset)
        soc_pkg::msip_offset: rdata <= {31'b0, msip};
        cmp_lo: rdata <= mtimecmp[31:0];
        cmp_hi: rdata <= mtimecmp[63:32];
        time_lo: rdata <= mtime[31:0];
        time_hi: rdata <= mtime[63:32];
        default: rdata <= '0;
      endcase
    end
  end

  assign rsp = '{ready: (state == respond), error: 1'b0, rdata: rdata};

endmodule

/* src/soc_bus.sv */
`timescale 1ns/1ps

module soc_bus #(
  parameter int ram_words = 64  // Must be a power of two
) (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_req_t cpu_req,
  output soc_pkg::mem_rsp_t cpu_rsp,
  output logic              msip,
  output logic              mtip
);

  soc_pkg::mem_req_t rom_req;
  soc_pkg::mem_req_t ram_req;
  soc_pkg::mem_req_t clint_req;
  soc_pkg::mem_rsp_t rom_rsp;
  soc_pkg::mem_rsp_t ram_rsp;
  soc_pkg::mem_rsp_t clint_rsp;

  bus_decoder #(.ram_words (ram_words)) decoder_comp (
    .clock (clock),
    .reset (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .rom_req (rom_req),
    .ram_req (ram_req),
    .clint_req (clint_req),
    .rom_rsp (rom_rsp),
    .ram_rsp (ram_rsp),
    .clint_rsp (clint_rsp)
  );

  boot_rom rom_comp (
    .clock (clock),
    .reset (reset),
    .req (rom_req),
    .rsp (rom_rsp)
  );

  scratch_ram #(.ram_words (ram_words)) ram_comp (
    .clock (clock),
    .reset (reset),
    .req (ram_req),
    .rsp (ram_rsp)
  );

  clint clint_comp (
    .clock (clock),
    .reset (reset),
    .req (clint_req),
    .rsp (clint_rsp),
    .msip (msip),
    .mtip (mtip)
  );

endmodule

/* test/soc_bus_tb.sv */
`timescale 1ns/1ps

module soc_bus_tb;

  localparam int ram_words = 64;
  localparam soc_pkg::addr_t rom_bytes = soc_pkg::addr_t'(4 * soc_pkg::rom_words);
  localparam soc_pkg::addr_t ram_bytes = soc_pkg::addr_t'(4 * ram_words);
  localparam int cycle_limit = 4000;  // All tests together take well under 2000 cycles

  logic clock;
  logic reset;
  soc_pkg::mem_req_t cpu_req;
  soc_pkg::mem_rsp_t cpu_rsp;
  logic msip;
  logic mtip;

  soc_pkg::data_t rom_image [soc_pkg::rom_words];
  soc_pkg::data_t ram_model [ram_words];
  logic msip_model;
  logic [31:0] seed;
  string test_name;
  int cycles = 0;
  int checks = 0;
  int errors = 0;
  int mark_checks = 0;
  int mark_errors = 0;

  soc_pkg::mem_rsp_t expect_q [$];
  bit data_q [$];
  soc_pkg::mem_rsp_t actual_q [$];
  int latency_q [$];
  event rsp_captured;

  soc_bus #(.ram_words (ram_words)) dut_i (
    .clock (clock),
    .reset (reset),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .msip (msip),
    .mtip (mtip)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Expected response of one access, updates the RAM and msip model on writes
  function automatic soc_pkg::mem_rsp_t expect_rsp(input soc_pkg::addr_t addr, input logic instr,
                                                   input soc_pkg::data_t wdata,
                                                   input soc_pkg::strb_t wstrb,
                                                   output bit check_data);
    soc_pkg::mem_rsp_t rsp;
    soc_pkg::addr_t ram_rel;
    soc_pkg::addr_t clint_rel;
    ram_rel = addr - soc_pkg::ram_base;
    clint_rel = addr - soc_pkg::clint_base;
    rsp = '{ready: 1'b1, error: 1'b0, rdata: '0};
    check_data = (wstrb == '0);  // Write data returned by a target has no meaning
    if (addr - soc_pkg::rom_base < rom_bytes) begin
      if (wstrb != '0) rsp.error = 1'b1;
      else rsp.rdata = rom_image[addr[5:2]];
    end else if (ram_rel < ram_bytes) begin
      if (wstrb == '0) rsp.rdata = ram_model[ram_rel >> 2];
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) ram_model[ram_rel >> 2][8*i +: 8] = wdata[8*i +: 8];
      end
    end else if (clint_rel < soc_pkg::clint_size) begin
      if (instr) begin
        rsp.error = 1'b1;
      end else if ({clint_rel[31:2], 2'b00} == soc_pkg::msip_offset) begin
        if (wstrb == '0) rsp.rdata = {31'b0, msip_model};
        else if (wstrb[0]) msip_model = wdata[0];
      end else begin
        check_data = 1'b0;  // Timer values are checked in the timer test
      end
    end else begin
      rsp.error = 1'b1;
    end
    if (rsp.error) check_data = 1'b1;
    return rsp;
  endfunction

  task automatic bus_access(input soc_pkg::addr_t addr, input logic instr,
                            input soc_pkg::data_t wdata, input soc_pkg::strb_t wstrb,
                            output soc_pkg::mem_rsp_t rsp);
    bit check_data;
    int latency;
    expect_q.push_back(expect_rsp(addr, instr, wdata, wstrb, check_data));
    data_q.push_back(check_data);
    @(posedge clock);
    cpu_req <= '{valid: 1'b1, instr: instr, addr: addr, wdata: wdata, wstrb: wstrb};
    latency = 0;
    do begin
      @(posedge clock);
      rsp = cpu_rsp;
      if (!rsp.ready) latency++;  // Cycles with valid high and no ready
    end while (!rsp.ready);
    cpu_req <= '0;
    actual_q.push_back(rsp);
    latency_q.push_back(latency);
    -> rsp_captured;
  endtask

  initial begin : compare_responses
    soc_pkg::mem_rsp_t expected;
    soc_pkg::mem_rsp_t actual;
    bit check_data;
    int latency;
    forever begin
      @(rsp_captured);
      while (actual_q.size() > 0) begin
        expected = expect_q.pop_front();
        check_data = data_q.pop_front();
        actual = actual_q.pop_front();
        latency = latency_q.pop_front();
        checks++;
        if (latency != 1) begin
          $display("Fail %s: ready latency expected 1, actual %0d", test_name, latency);
          errors++;
        end
        if (actual.error !== expected.error) begin
          $display("Fail %s: error expected %b, actual %b", test_name, expected.error,
                   actual.error);
          errors++;
        end
        if (check_data && actual.rdata !== expected.rdata) begin
          $display("Fail %s: rdata expected %h, actual %h", test_name, expected.rdata,
                   actual.rdata);
          errors++;
        end
      end
    end
  end

  task automatic check_bit(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      $display("Fail %s: %s expected %b, actual %b", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_for_mtip(input logic level, input int limit);
    int n;
    n = 0;
    while (mtip !== level && n < limit) begin
      @(posedge clock);
      n++;
    end
    check_bit("mtip", level, mtip);
  endtask

  task automatic finish_test();
    @(posedge clock);
    $display("%-16s %0d checks, %0d errors", test_name, checks - mark_checks,
             errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  initial begin
    soc_pkg::mem_rsp_t rsp;
    soc_pkg::addr_t addr;
    soc_pkg::strb_t strb;
    logic [31:0] r;
    reset = 1'b0;
    cpu_req = '0;
    seed = 32'd65508;
    msip_model = 1'b0;
    $readmemh("src/boot_rom.hex", rom_image);
    repeat (4) @(posedge clock);
    reset <= 1'b1;

    test_name = "rom_read";
    for (int i = 0; i < soc_pkg::rom_words; i++) begin
      bus_access(soc_pkg::rom_base + 4 * i, i[0], '0, '0, rsp);
    end
    finish_test();

    test_name = "ram_random";
    for (int i = 0; i < ram_words; i++) begin
      addr = soc_pkg::ram_base + 4 * i;
      bus_access(addr, 1'b0, ~addr ^ (addr << 13), 4'hf, rsp);  // Defined contents first
    end
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      addr = soc_pkg::ram_base + 4 * ((r >> 8) % ram_words);
      strb = (r[27:24] == '0) ? 4'hf : r[27:24];
      bus_access(addr, 1'b0, next_rand(), strb, rsp);
      bus_access(addr, 1'b0, '0, '0, rsp);
    end
    finish_test();

    test_name = "error_response";
    bus_access(soc_pkg::rom_base + 8, 1'b0, 32'hdead_beef, 4'hf, rsp);
    bus_access(soc_pkg::clint_base + 4, 1'b1, '0, '0, rsp);
    bus_access(32'h1000_0000, 1'b0, '0, '0, rsp);
    bus_access(soc_pkg::ram_base + ram_bytes, 1'b0, 32'h1234_5678, 4'h3, rsp);
    finish_test();

    test_name = "msip";
    bus_access(soc_pkg::clint_base + soc_pkg::msip_offset, 1'b0, 32'h1, 4'h1, rsp);
    check_bit("msip output", 1'b1, msip);
    bus_access(soc_pkg::clint_base + soc_pkg::msip_offset, 1'b0, '0, '0, rsp);
    bus_access(soc_pkg::clint_base + soc_pkg::msip_offset, 1'b0, 32'h0, 4'h1, rsp);
    check_bit("msip output", 1'b0, msip);
    bus_access(soc_pkg::clint_base + soc_pkg::msip_offset, 1'b0, '0, '0, rsp);
    finish_test();

    test_name = "timer";
    bus_access(soc_pkg::clint_base + soc_pkg::mtime_offset, 1'b0, '0, 4'hf, rsp);
    bus_access(soc_pkg::clint_base + soc_pkg::mtime_offset + 4, 1'b0, '0, 4'hf, rsp);
    bus_access(soc_pkg::clint_base + soc_pkg::mtime_offset, 1'b0, '0, '0, rsp);
    checks++;
    if (rsp.rdata >= 20) begin
      $display("Fail %s: mtime low expected below 20, actual %0d", test_name, rsp.rdata);
      errors++;
    end
    bus_access(soc_pkg::clint_base + soc_pkg::mtimecmp_offset + 4, 1'b0, '0, 4'hf, rsp);
    bus_access(soc_pkg::clint_base + soc_pkg::mtimecmp_offset, 1'b0, 32'd100, 4'hf, rsp);
    wait_for_mtip(1'b1, 200);
    bus_access(soc_pkg::clint_base + soc_pkg::mtimecmp_offset + 4, 1'b0, '1, 4'hf, rsp);
    wait_for_mtip(1'b0, 4);
    finish_test();

    $display("Total %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* list.f */
src/soc_pkg.sv
src/bus_decoder.sv
src/boot_rom.sv
src/scratch_ram.sv
src/clint.sv
src/soc_bus.sv
test/soc_bus_tb.sv

/* src/boot_rom.hex */
// One 32-bit word per line, word 0 at address 0
00010137
10010113
020002b7
00100313
0062a023
00000013
0000006f
13579bdf
2468ace0
deadbeef
0badf00d
c0ffee00
5a5aa5a5
12345678
89abcdef
fedcba98
